/* flist.f */
rtl/adxl_pkg.sv
rtl/tag_queue.sv
rtl/spi_frame_engine.sv
rtl/sample_packer.sv
rtl/adxl_reader_top.sv
verif/adxl_slave_model.sv
verif/tb_adxl_reader.sv

/* rtl/adxl_pkg.sv */
//####################################################################
// shared constants and the sample byte view for the dual ADXL355 reader
// imported by wildcard in the module headers that need them
//####################################################################
package adxl_pkg;

  // tag queue geometry
  localparam int tag_addr_bits = 4;                // 16 chars of tag storage
  localparam int tag_depth     = 2 ** tag_addr_bits;

  // frame index layout: upper nibble counts bytes, low nibble half-bit steps
  localparam int bit_slots = 4;                    // low index bits per byte

  // fixed steps at the start of a frame
  localparam logic [7:0] csn_low_step = 8'd1;      // chip select falls here
  localparam logic [7:0] sclk_on_step = 8'd2;      // serial clock and cmd load

  // low nibble offsets appended to len at the end of a frame
  localparam logic [3:0] end_offset_sclk = 4'h2;   // serial clock stops
  localparam logic [3:0] end_offset_csn  = 4'h3;   // chip select rises
  localparam logic [3:0] end_offset_done = 4'h4;   // frame finished, idle here

  // channel 1 holds one xyz triple of 16-bit words
  localparam int ch1_buf_len = 6;

  // tag characters, 6-bit ascii subset
  localparam logic [5:0] tag_char_pulse = 6'h21;   // "!"
  localparam logic [5:0] tag_char_idle  = 6'h20;   // space

  // received byte, either whole or split into payload and tag lsb
  typedef union packed {
    logic [7:0] raw;                               // byte as shifted in
    struct packed {
      logic [6:0] payload;                         // upper sample bits
      logic       tag_bit;                         // lsb carries one tag bit
    } tag_view;
  } sample_byte_u;

endpackage

/* rtl/adxl_reader_top.sv */
//####################################################################
// buffered SPI reader for two ADXL355 sensors with tag embedding
// drives the shared SPI bus and a byte-write stream towards a BRAM
//####################################################################
`timescale 1ns/1ps

module adxl_reader_top
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clk_en,         // frame pacing tick
  input  logic       sclk_phase,
  input  logic       sclk_polarity,
  input  logic       direct,         // request direct sensor access
  input  logic       tag_pulse,      // queue "!" for the next frame
  input  logic       tag_en,         // push tag char
  input  logic [5:0] tag,
  input  logic       sync,           // start a frame
  input  logic [7:0] cmd,
  input  logic [3:0] len,            // bytes incl. cmd
  input  logic       miso0,
  input  logic       miso1,
  output logic       direct_en,      // grant for the external mux
  output logic       mosi,
  output logic       sclk,
  output logic       csn,
  output logic [7:0] wrdata,
  output logic       wr,
  output logic       wr16,
  output logic       x
);

  logic       frame_start;
  logic       frame_end;
  logic       byte_done;
  logic [3:0] byte_num;
  logic [7:0] rx0;
  logic [7:0] rx1;
  logic [5:0] tag_char;

  tag_queue u_tag_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_en      (tag_en),
    .tag_pulse   (tag_pulse),
    .frame_start (frame_start),
    .tag         (tag),
    .tag_char    (tag_char)
  );

  spi_frame_engine u_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .clk_en        (clk_en),
    .sync          (sync),
    .direct        (direct),
    .sclk_phase    (sclk_phase),
    .sclk_polarity (sclk_polarity),
    .cmd           (cmd),
    .len           (len),
    .miso0         (miso0),
    .miso1         (miso1),
    .mosi          (mosi),
    .sclk          (sclk),
    .csn           (csn),
    .direct_en     (direct_en),
    .frame_start   (frame_start),
    .frame_end     (frame_end),
    .byte_done     (byte_done),
    .byte_num      (byte_num),
    .rx0           (rx0),
    .rx1           (rx1)
  );

  sample_packer u_packer (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .byte_done   (byte_done),
    .byte_num    (byte_num),
    .rx0         (rx0),
    .rx1         (rx1),
    .tag_char    (tag_char),
    .wrdata      (wrdata),
    .wr          (wr),
    .wr16        (wr16),
    .x           (x)
  );

endmodule

/* rtl/sample_packer.sv */
//####################################################################
// hides tag bits in sample lsbs and builds the BRAM write stream
// ch0 bytes go out as they arrive, ch1 follows as a burst after the frame
//####################################################################
`timescale 1ns/1ps

module sample_packer import adxl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       frame_start,
  input  logic       frame_end,
  input  logic       byte_done,
  input  logic [3:0] byte_num,
  input  logic [7:0] rx0,
  input  logic [7:0] rx1,
  input  logic [5:0] tag_char,
  output logic [7:0] wrdata,
  output logic       wr,          // every data byte
  output logic       wr16,        // skips every 3rd byte
  output logic       x            // first data byte of the frame
);

  logic         data_byte;        // past the command byte
  logic         wide_byte;        // qualifies for wr16
  logic         mark;             // set: this wide byte carries tag bits
  logic [1:0]   bit_i;            // tag bit index for ch0, +3 for ch1
  logic [2:0]   widx;             // ch1 buffer fill
  logic [2:0]   ridx;             // ch1 buffer drain
  logic         burst;            // ch1 burst in progress
  logic         wr_q;
  logic         wr16_q;
  logic [7:0]   ch0_q;            // ch0 byte on the bus
  logic [7:0]   ch1_buf [ch1_buf_len];
  sample_byte_u b0;
  sample_byte_u b1;

  assign data_byte = byte_done && (byte_num != 4'd0);
  assign wide_byte = data_byte && (byte_num != 4'd3) && (byte_num != 4'd6)
                     && (byte_num != 4'd9);

  // tag insertion through the lsb view
  always_comb
  begin
    b0.raw = rx0;
    b1.raw = rx1;
    if (wide_byte && mark)
    begin
      b0.tag_view.tag_bit = tag_char[bit_i];                 // bits 0..2
      b1.tag_view.tag_bit = tag_char[{1'b0, bit_i} + 3'd3];  // bits 3..5
    end
  end

  // tag position tracking and ch1 fill, restarted per frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mark  <= 1'b0;
      bit_i <= '0;
      widx  <= '0;
    end
    else if (frame_start)
    begin
      mark  <= 1'b0;
      bit_i <= '0;
      widx  <= '0;
    end
    else if (wide_byte)
    begin
      mark <= !mark;
      if (mark)
        bit_i <= (bit_i == 2'd2) ? 2'd0 : bit_i + 2'd1;  // 3 bits per channel
      if (widx != 3'(ch1_buf_len))
        widx <= widx + 3'd1;                              // extra bytes dropped
    end
  end

  always_ff @(posedge clk)
  begin
    if (data_byte)
      ch0_q <= b0.raw;
    if (wide_byte && widx != 3'(ch1_buf_len))
      ch1_buf[widx] <= b1.raw;
  end

  // strobes, burst after frame_end
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_q   <= 1'b0;
      wr16_q <= 1'b0;
      x      <= 1'b0;
      burst  <= 1'b0;
      ridx   <= '0;
    end
    else
    begin
      wr_q   <= data_byte;
      wr16_q <= wide_byte;
      x      <= data_byte && (byte_num == 4'd1);
      if (frame_end)
      begin
        burst <= 1'b1;
        ridx  <= '0;
      end
      else if (burst)
      begin
        if (ridx == 3'(ch1_buf_len - 1))
          burst <= 1'b0;                  // 6 writes done
        else
          ridx <= ridx + 3'd1;
      end
    end
  end

  assign wrdata = burst ? ch1_buf[ridx] : ch0_q;
  assign wr     = wr_q | burst;
  assign wr16   = wr16_q | burst;        // burst bytes are all 16-bit data

endmodule

/* rtl/spi_frame_engine.sv */
//####################################################################
// SPI frame sequencer for two sensors on a shared csn, sclk and mosi
// runs one frame of len bytes per sync, paced by clk_en
//####################################################################
`timescale 1ns/1ps

module spi_frame_engine import adxl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clk_en,         // pacing tick, slower than clk
  input  logic       sync,           // start request
  input  logic       direct,         // direct access request
  input  logic       sclk_phase,     // 0 for ADXL355
  input  logic       sclk_polarity,  // 0 for ADXL355
  input  logic [7:0] cmd,            // command byte, sent first
  input  logic [3:0] len,            // bytes per frame incl. cmd
  input  logic       miso0,
  input  logic       miso1,
  output logic       mosi,
  output logic       sclk,
  output logic       csn,
  output logic       direct_en,      // grant level, changes only between frames
  output logic       frame_start,    // 1-clk pulse as the index restarts
  output logic       frame_end,      // 1-clk pulse as the index hits the end
  output logic       byte_done,      // 1-clk pulse, rx0/rx1 hold a full byte
  output logic [3:0] byte_num,       // 0 is the command byte
  output logic [7:0] rx0,
  output logic [7:0] rx1
);

  logic [7:0] index;      // upper nibble byte count, low nibble half-bit steps
  logic [7:0] cmd_q;      // cmd latched per frame
  logic [3:0] len_q;      // len latched per frame
  logic       sclk_en;    // sclk toggles only inside the frame
  logic       sclk_q;     // clock before polarity
  logic [7:0] mosi_sr;    // msb first out
  logic [7:0] byte_mark;  // one-hot, bit 7 marks the last bit of a byte
  logic       at_end;
  logic       half_step;  // even ticks move the shifters

  assign at_end    = index == {len_q, end_offset_done};
  assign half_step = clk_en && !index[0];

  // frame index, idles at the end position until the next sync
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      index       <= {4'd0, end_offset_done};  // finished state
      len_q       <= 4'd0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end
    else
    begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      if (at_end)
      begin
        if (sync && !direct_en)              // no new frames while granted
        begin
          index       <= '0;
          len_q       <= len;
          frame_start <= 1'b1;
        end
      end
      else if (clk_en)
      begin
        index     <= index + 8'd1;
        frame_end <= (index + 8'd1) == {len_q, end_offset_done};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (at_end && sync && !direct_en)
      cmd_q <= cmd;
  end

  // bus lines and grant, all stepped by clk_en
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      csn       <= 1'b1;
      sclk_en   <= 1'b0;
      sclk_q    <= 1'b0;
      direct_en <= 1'b0;
    end
    else if (clk_en)
    begin
      if (index == csn_low_step)
        csn <= 1'b0;
      else if (index == {len_q, end_offset_csn})
        csn <= 1'b1;
      if (index == sclk_on_step)
        sclk_en <= 1'b1;
      else if (index == {len_q, end_offset_sclk})
        sclk_en <= 1'b0;
      sclk_q <= (index[0] ^ sclk_phase) & sclk_en;  // two ticks per bit
      if (at_end)
        direct_en <= direct;                        // switch only when idle
    end
  end

  assign sclk = sclk_q ^ sclk_polarity;
  assign mosi = mosi_sr[7];

  // mosi shifter and byte boundary tracking
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mosi_sr   <= '0;
      byte_mark <= '0;
      byte_done <= 1'b0;
      byte_num  <= '0;
    end
    else
    begin
      byte_done <= 1'b0;
      if (half_step)
      begin
        if (index == sclk_on_step)
        begin
          mosi_sr   <= cmd_q;                   // cmd, then zeros
          byte_mark <= 8'h01;
        end
        else
        begin
          mosi_sr   <= {mosi_sr[6:0], 1'b0};
          byte_mark <= {byte_mark[6:0], byte_mark[7]};
        end
        if (byte_mark[7] && sclk_en)
        begin
          byte_done <= 1'b1;
          byte_num  <= index[7:bit_slots] - 4'd1;  // byte 0 ends in nibble 1
        end
      end
    end
  end

  // miso shifters, the byte is whole on byte_done
  always_ff @(posedge clk)
  begin
    if (half_step)
    begin
      rx0 <= {rx0[6:0], miso0};
      rx1 <= {rx1[6:0], miso1};
    end
  end

endmodule

/* rtl/tag_queue.sv */
//####################################################################
// tag character FIFO, one char handed to the packer at each frame start
// pulse tag "!" wins over queued chars, empty queue yields a space
//####################################################################
`timescale 1ns/1ps

module tag_queue import adxl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tag_en,       // push tag into the queue
  input  logic       tag_pulse,    // request "!" for the next frame
  input  logic       frame_start,  // pop one char for the new frame
  input  logic [5:0] tag,          // char to push
  output logic [5:0] tag_char      // char in use, stable over the frame
);

  logic [5:0]             mem [tag_depth];  // char storage
  logic [tag_addr_bits:0] wptr;             // extra msb tells full from empty
  logic [tag_addr_bits:0] rptr;
  logic                   pulse_pend;       // "!" waiting for a frame
  logic                   empty;
  logic                   full;

  assign empty = wptr == rptr;
  assign full  = (wptr ^ rptr) == {1'b1, {tag_addr_bits{1'b0}}}; // wrapped once

  // pulse stays pending until a frame picks it up
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pulse_pend <= 1'b0;
    else if (tag_pulse)
      pulse_pend <= 1'b1;                   // new pulse wins over the clear
    else if (frame_start)
      pulse_pend <= 1'b0;
  end

  // push side, writes into a full queue are lost
  always_ff @(posedge clk)
  begin
    if (tag_en && !full)
      mem[wptr[tag_addr_bits-1:0]] <= tag;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wptr <= '0;
    else if (tag_en && !full)
      wptr <= wptr + 1'b1;
  end

  // pop side, tag_char is the registered read port
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rptr     <= '0;
      tag_char <= tag_char_idle;
    end
    else if (frame_start)
    begin
      if (pulse_pend)
        tag_char <= tag_char_pulse;         // queue untouched
      else if (empty)
        tag_char <= tag_char_idle;          // nothing queued
      else
      begin
        tag_char <= mem[rptr[tag_addr_bits-1:0]];
        rptr     <= rptr + 1'b1;            // pop
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tb_adxl_reader -o sim_adxl
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_adxl > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
exit 1

/* verif/adxl_slave_model.sv */
//####################################################################
// behavioral SPI sensor, mode 0, returns base + byte index on miso
// latches the first byte seen on mosi as the command
//####################################################################
`timescale 1ns/1ps

module adxl_slave_model
(
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  input  logic [7:0] base,      // byte k of a frame reads back as base + k
  output logic       miso,
  output logic [7:0] cmd_rx     // command byte of the last frame
);

  int unsigned nbits = 0;       // rising edges seen in this frame
  logic [7:0]  cur;             // byte being sent
  logic [2:0]  bsel;            // bit position in cur

  initial
  begin
    miso   = 1'b0;
    cmd_rx = 8'h00;
  end

  // bit count restarts while chip select is high
  always @(posedge sclk or posedge csn)
  begin
    if (csn)
      nbits <= 0;
    else
    begin
      if (nbits < 8)
        cmd_rx <= {cmd_rx[6:0], mosi};   // msb first
      nbits <= nbits + 1;
    end
  end

  // first bit as chip select falls, next bits on the falling clock edge
  // master samples on the rising one
  always @(negedge csn or negedge sclk)
  begin
    if (!csn)
    begin
      cur  = base + 8'(nbits / 8);
      bsel = 3'(7 - (nbits % 8));
      miso <= cur[bsel];
    end
  end

endmodule

/* verif/tb_adxl_reader.sv */
//####################################################################
// table driven testbench for the dual ADXL355 reader
// each row runs one frame, the write stream is checked against a model
//####################################################################
`timescale 1ns/1ps

module tb_adxl_reader import adxl_pkg::*; ();

  localparam int n_rows   = 6;
  localparam int wait_max = 4000;              // clocks per wait
  localparam logic [7:0] base0 = 8'h40;        // ch0 sensor pattern
  localparam logic [7:0] base1 = 8'hA5;        // ch1 sensor pattern

  // frame table: cmd, len, tags pushed, pulse, direct, expected tag
  logic [7:0] t_cmd    [n_rows] = '{8'h11, 8'hA3, 8'h5C, 8'h08, 8'hF1, 8'h3E};
  logic [3:0] t_len    [n_rows] = '{4'd9, 4'd12, 4'd10, 4'd11, 4'd15, 4'd9};
  int         t_ntags  [n_rows] = '{2, 0, 0, 0, 1, 1};
  logic [5:0] t_tag0   [n_rows] = '{6'h30, 6'h00, 6'h00, 6'h00, 6'h3F, 6'h2A};
  logic [5:0] t_tag1   [n_rows] = '{6'h31, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00};
  logic       t_pulse  [n_rows] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
  logic       t_direct [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  logic [5:0] t_exp    [n_rows] = '{6'h30, 6'h21, 6'h31, 6'h20, 6'h3F, 6'h2A};

  logic       clk = 1'b0;
  logic       rst_n;
  logic       clk_en = 1'b0;
  logic [1:0] div = 2'd0;
  logic       sclk_phase, sclk_polarity, direct, tag_pulse, tag_en, sync;
  logic [5:0] tag;
  logic [7:0] cmd;
  logic [3:0] len;
  logic       miso0, miso1, direct_en, mosi, sclk, csn, wr, wr16, x;
  logic [7:0] wrdata, cmd_rx0, cmd_rx1;

  logic [7:0] got_data [$];                    // monitor capture
  logic       got_w16  [$];
  logic       got_x    [$];
  logic [7:0] exp_data [$];                    // model stream
  logic       exp_w16  [$];
  logic       exp_x    [$];
  int         errors   = 0;
  int         timeouts = 0;

  adxl_reader_top u_dut (
    .clk (clk), .rst_n (rst_n), .clk_en (clk_en),
    .sclk_phase (sclk_phase), .sclk_polarity (sclk_polarity),
    .direct (direct), .tag_pulse (tag_pulse), .tag_en (tag_en), .tag (tag),
    .sync (sync), .cmd (cmd), .len (len), .miso0 (miso0), .miso1 (miso1),
    .direct_en (direct_en), .mosi (mosi), .sclk (sclk), .csn (csn),
    .wrdata (wrdata), .wr (wr), .wr16 (wr16), .x (x)
  );

  adxl_slave_model u_sensor0 (.csn (csn), .sclk (sclk), .mosi (mosi), .base (base0),
                              .miso (miso0), .cmd_rx (cmd_rx0));
  adxl_slave_model u_sensor1 (.csn (csn), .sclk (sclk), .mosi (mosi), .base (base1),
                              .miso (miso1), .cmd_rx (cmd_rx1));

  always #20 clk = ~clk;                       // 40 ns period

  always @(posedge clk)
  begin
    div    <= div + 2'd1;
    clk_en <= (div == 2'd3);                   // one tick every 4 clocks
  end

  // collect every write of the stream
  always @(posedge clk)
  begin
    if (rst_n === 1'b1 && wr === 1'b1)
    begin
      got_data.push_back(wrdata);
      got_w16.push_back(wr16);
      got_x.push_back(x);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] actv);
    assert (expv === actv)
    else
    begin
      $display("Error %s: expected %0h, actual %0h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic wait_csn(input logic level, input string what);
    int n;
    n = 0;
    while (csn !== level && n < wait_max)
    begin
      @(posedge clk);
      n++;
    end
    if (csn !== level)
    begin
      $display("timed out waiting for %s", what);
      timeouts++;
    end
  endtask

  task automatic wait_grant(input logic level);
    int n;
    n = 0;
    while (direct_en !== level && n < wait_max)
    begin
      @(posedge clk);
      n++;
    end
    if (direct_en !== level)
    begin
      $display("timed out waiting for direct_en to become %0b", level);
      timeouts++;
    end
  endtask

  task automatic wait_writes(input int count);
    int n;
    n = 0;
    while (got_data.size() < count && n < wait_max)
    begin
      @(posedge clk);
      n++;
    end
    if (got_data.size() < count)
    begin
      $display("timed out waiting for the channel 1 burst to finish");
      timeouts++;
    end
  endtask

  // ch0 bytes in order, then the first six wide ch1 bytes as a burst
  task automatic build_expected(input logic [3:0] flen, input logic [5:0] tagc);
    logic [7:0] d0;
    logic [7:0] d1;
    logic [7:0] ch1 [$];
    logic       wide;
    int         w;
    w = 0;
    exp_data.delete();
    exp_w16.delete();
    exp_x.delete();
    for (int n = 1; n < int'(flen); n++)
    begin
      d0   = base0 + 8'(n);
      d1   = base1 + 8'(n);
      wide = (n != 3) && (n != 6) && (n != 9);
      if (wide)
      begin
        if (w % 2 == 1)
        begin
          d0[0] = tagc[3'(((w - 1) / 2) % 3)];      // tag bits 0..2
          d1[0] = tagc[3'(((w - 1) / 2) % 3 + 3)];  // tag bits 3..5
        end
        if (w < ch1_buf_len)
          ch1.push_back(d1);
        w++;
      end
      exp_data.push_back(d0);
      exp_w16.push_back(wide);
      exp_x.push_back(n == 1);
    end
    foreach (ch1[k])
    begin
      exp_data.push_back(ch1[k]);
      exp_w16.push_back(1'b1);
      exp_x.push_back(1'b0);
    end
  endtask

  // pull the tag char back out of the captured stream
  task automatic check_tag(input logic [3:0] flen, input logic [5:0] expc);
    sample_byte_u u;
    logic [5:0]   dec;
    int           w;
    int           nch0;
    w    = 0;
    dec  = 6'h00;
    nch0 = int'(flen) - 1;
    for (int k = 0; k < nch0 && k < got_data.size(); k++)
    begin
      u.raw = got_data[k];
      if (got_w16[k])
      begin
        if (w % 2 == 1 && w < 6)
          dec[3'((w - 1) / 2)] = u.tag_view.tag_bit;
        w++;
      end
    end
    for (int k = 1; k < ch1_buf_len && nch0 + k < got_data.size(); k += 2)
    begin
      u.raw = got_data[nch0 + k];
      dec[3'(3 + (k - 1) / 2)] = u.tag_view.tag_bit;
    end
    check_value("tag character", 32'(expc), 32'(dec));
  endtask

  // grant is taken after the frame, syncs are ignored, then released
  task automatic direct_phase();
    int lowcnt;
    lowcnt = 0;
    wait_grant(1'b1);
    got_data.delete();
    @(posedge clk);
    sync <= 1'b1;
    @(posedge clk);
    sync <= 1'b0;
    repeat (200)
    begin
      @(posedge clk);
      if (csn !== 1'b1)
        lowcnt++;
    end
    check_value("direct csn low cycles", 32'd0, 32'(lowcnt));
    check_value("direct write count", 32'd0, 32'(got_data.size()));
    direct <= 1'b0;
    wait_grant(1'b0);
  endtask

  initial
  begin
    #10_000_000;
    $display("simulation watchdog expired, the run is stuck");
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    rst_n         = 1'b0;
    sclk_phase    = 1'b0;                      // sensors run mode 0
    sclk_polarity = 1'b0;
    direct        = 1'b0;
    tag_pulse     = 1'b0;
    tag_en        = 1'b0;
    tag           = 6'h00;
    sync          = 1'b0;
    cmd           = 8'h00;
    len           = 4'd0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (40)                                // idle, no sync
    begin
      @(posedge clk);
      check_value("idle csn", 32'd1, 32'(csn));
      check_value("idle wr", 32'd0, 32'(wr));
      check_value("idle x", 32'd0, 32'(x));
      check_value("idle direct_en", 32'd0, 32'(direct_en));
    end
    check_value("idle write count", 32'd0, 32'(got_data.size()));

    for (int r = 0; r < n_rows; r++)
    begin
      if (timeouts != 0)
        break;
      for (int k = 0; k < t_ntags[r]; k++)
      begin
        @(posedge clk);
        tag    <= (k == 0) ? t_tag0[r] : t_tag1[r];
        tag_en <= 1'b1;
        @(posedge clk);
        tag_en <= 1'b0;
      end
      if (t_pulse[r])
      begin
        @(posedge clk);
        tag_pulse <= 1'b1;
        @(posedge clk);
        tag_pulse <= 1'b0;
      end
      build_expected(t_len[r], t_exp[r]);
      got_data.delete();
      got_w16.delete();
      got_x.delete();
      @(posedge clk);
      sync <= 1'b1;
      cmd  <= t_cmd[r];
      len  <= t_len[r];
      @(posedge clk);
      sync <= 1'b0;
      if (t_direct[r])
        direct <= 1'b1;                        // request during the frame
      wait_csn(1'b0, "chip select to fall");
      wait_csn(1'b1, "chip select to rise");
      if (t_direct[r])
        check_value("direct_en before frame end", 32'd0, 32'(direct_en));
      wait_writes(exp_data.size());
      repeat (16) @(posedge clk);              // catch extra writes
      check_value("cmd on sensor 0", 32'(t_cmd[r]), 32'(cmd_rx0));
      check_value("cmd on sensor 1", 32'(t_cmd[r]), 32'(cmd_rx1));
      check_value("write count", 32'(int'(t_len[r]) - 1 + ch1_buf_len),
                  32'(got_data.size()));
      for (int k = 0; k < exp_data.size() && k < got_data.size(); k++)
      begin
        check_value($sformatf("row %0d byte %0d wrdata", r, k), 32'(exp_data[k]),
                    32'(got_data[k]));
        check_value($sformatf("row %0d byte %0d wr16", r, k), 32'(exp_w16[k]),
                    32'(got_w16[k]));
        check_value($sformatf("row %0d byte %0d x", r, k), 32'(exp_x[k]),
                    32'(got_x[k]));
      end
      check_tag(t_len[r], t_exp[r]);
      if (t_direct[r])
        direct_phase();
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
